// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_sorter
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/sorter_ctrl_pkg.sv
`include "sorter_defs.svh"

package sorter_ctrl_pkg;

    //////////////////////////////
    // Indices
    //////////////////////////////

    typedef logic [`SORTER_RANK_W-1:0] rank_t;
    typedef logic [`SORTER_RANK_W-1:0] slot_t;

    //////////////////////////////
    // Pipeline stage results
    //////////////////////////////

    // Stage 1, one bit per slot, set where the new sample is greater
    typedef struct packed {
        logic                       valid;
        sorter_data_pkg::data_t     data;
        slot_t                      slot;
        logic [`SORTER_WINDOW-1:0]  gt;
    } cmp_t;

    // Stage 2, sample with its rank among the surviving entries
    typedef struct packed {
        logic                       valid;
        sorter_data_pkg::data_t     data;
        slot_t                      slot;
        rank_t                      rank;
    } ins_t;

    // Order scan FSM
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        EMIT
    } scan_state_e;

    // Indexed by rank, holds a slot
    typedef slot_t [`SORTER_WINDOW-1:0] order_table_t;

    // Indexed by slot, holds a rank
    typedef rank_t [`SORTER_WINDOW-1:0] slot_rank_table_t;

endpackage

// File: common/sorter_data_pkg.sv
`include "sorter_defs.svh"

package sorter_data_pkg;

    //////////////////////////////
    // Sample values
    //////////////////////////////

    // One stream sample
    typedef logic [`SORTER_DATA_W-1:0] data_t;

    // Eight smallest window values, index 0 is rank 0
    typedef data_t [`SORTER_OUT_RANKS-1:0] rank_vec_t;

endpackage

// File: common/sorter_defs.svh
`ifndef SORTER_DEFS_SVH
`define SORTER_DEFS_SVH

// Sample width in bits
`define SORTER_DATA_W 16

// Number of window slots
`define SORTER_WINDOW 15

// Width of a rank or a slot index
`define SORTER_RANK_W 4

// Ranks presented at the output, smallest first
`define SORTER_OUT_RANKS 8

// One order entry per cycle
`define SORTER_SCAN_LEN `SORTER_WINDOW

`endif

// File: rtl/sorter_compare.sv
`include "sorter_defs.svh"

module sorter_compare (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        src_vld_i,
    input  sorter_data_pkg::data_t                      src_data_i,
    input  sorter_data_pkg::data_t [`SORTER_WINDOW-1:0] window_data_i,
    input  sorter_ctrl_pkg::slot_t                      oldest_slot_i,
    output sorter_ctrl_pkg::cmp_t                       cmp_o
);
    import sorter_data_pkg::*;
    import sorter_ctrl_pkg::*;

    logic                       vld_q;
    data_t                      data_q;
    logic [`SORTER_WINDOW-1:0]  gt;

    // Input capture
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= src_vld_i;
        end
        if (src_vld_i) begin
            data_q <= src_data_i;
        end
    end

    // Strict compare, the slot about to be evicted never counts
    always_comb begin
        for (int k = 0; k < `SORTER_WINDOW; k++) begin
            gt[k] = (data_q > window_data_i[k]) && (slot_t'(k) != oldest_slot_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmp_o.valid <= 1'b0;
        end else begin
            cmp_o.valid <= vld_q;
        end
        if (vld_q) begin
            cmp_o.data <= data_q;
            cmp_o.slot <= oldest_slot_i;
            cmp_o.gt   <= gt;
        end
    end

endmodule

// File: rtl/sorter_order_scan.sv
`include "sorter_defs.svh"

module sorter_order_scan (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  sorter_ctrl_pkg::slot_rank_table_t   slot_ranks_i,
    input  logic                                update_i,
    output sorter_ctrl_pkg::order_table_t       order_o,
    output logic                                done_o
);
    import sorter_ctrl_pkg::*;

    scan_state_e    state_q;
    slot_t          slot_cnt;
    logic           scan_step;

    // Slot 0 goes out on the edge that leaves IDLE
    assign scan_step = (state_q == IDLE && update_i) || (state_q == SCAN);

    //////////////////////////////
    // Scan FSM
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= IDLE;
            slot_cnt <= '0;
            for (int k = 0; k < `SORTER_WINDOW; k++) begin
                order_o[k] <= slot_t'(k);
            end
        end else begin
            if (scan_step) begin
                order_o[slot_ranks_i[slot_cnt]] <= slot_cnt;
            end
            case (state_q)
                IDLE: begin
                    if (update_i) begin
                        state_q  <= SCAN;
                        slot_cnt <= slot_t'(1);
                    end
                end
                SCAN: begin
                    if (slot_cnt == slot_t'(`SORTER_SCAN_LEN - 1)) begin
                        state_q  <= EMIT;
                        slot_cnt <= '0;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                EMIT: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q  <= IDLE;
                    slot_cnt <= '0;
                end
            endcase
        end
    end

    // Table complete while in EMIT
    assign done_o = (state_q == EMIT);

endmodule

// File: rtl/sorter_output.sv
`include "sorter_defs.svh"

module sorter_output (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        done_i,
    input  sorter_ctrl_pkg::order_table_t               order_i,
    input  sorter_data_pkg::data_t [`SORTER_WINDOW-1:0] window_data_i,
    output logic                                        reorder_vld_o,
    output sorter_data_pkg::rank_vec_t                  reorder_ranks_o
);

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reorder_vld_o <= 1'b0;
        end else begin
            reorder_vld_o <= done_i;
        end
        // Ranks hold until the next scan completes
        if (done_i) begin
            for (int r = 0; r < `SORTER_OUT_RANKS; r++) begin
                reorder_ranks_o[r] <= window_data_i[order_i[r]];
            end
        end
    end

endmodule

// File: rtl/sorter_rank_count.sv
`include "sorter_defs.svh"

module sorter_rank_count (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sorter_ctrl_pkg::cmp_t   cmp_i,
    output sorter_ctrl_pkg::ins_t   ins_o
);
    import sorter_ctrl_pkg::*;

    rank_t count;

    // Population count of the compare vector
    always_comb begin
        count = '0;
        for (int k = 0; k < `SORTER_WINDOW; k++) begin
            count = count + rank_t'(cmp_i.gt[k]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ins_o.valid <= 1'b0;
        end else begin
            ins_o.valid <= cmp_i.valid;
        end
        if (cmp_i.valid) begin
            ins_o.data <= cmp_i.data;
            ins_o.slot <= cmp_i.slot;
            ins_o.rank <= count;
        end
    end

endmodule

// File: rtl/sorter_top.sv
`include "sorter_defs.svh"

module sorter_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        src_vld_i,
    input  sorter_data_pkg::data_t      src_data_i,
    output logic                        reorder_vld_o,
    output sorter_data_pkg::rank_vec_t  reorder_ranks_o
);
    import sorter_data_pkg::*;
    import sorter_ctrl_pkg::*;

    cmp_t                           cmp;
    ins_t                           ins;
    data_t [`SORTER_WINDOW-1:0]     window_data;
    slot_t                          oldest_slot;
    slot_rank_table_t               slot_ranks;
    logic                           update;
    order_table_t                   order;
    logic                           done;

    //////////////////////////////
    // Insertion path
    //////////////////////////////

    sorter_compare u_compare (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .src_vld_i      (src_vld_i),
        .src_data_i     (src_data_i),
        .window_data_i  (window_data),
        .oldest_slot_i  (oldest_slot),
        .cmp_o          (cmp)
    );

    sorter_rank_count u_rank_count (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .cmp_i  (cmp),
        .ins_o  (ins)
    );

    sorter_window u_window (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .ins_i          (ins),
        .window_data_o  (window_data),
        .oldest_slot_o  (oldest_slot),
        .slot_ranks_o   (slot_ranks),
        .update_o       (update)
    );

    //////////////////////////////
    // Readout path
    //////////////////////////////

    sorter_order_scan u_order_scan (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .slot_ranks_i   (slot_ranks),
        .update_i       (update),
        .order_o        (order),
        .done_o         (done)
    );

    sorter_output u_output (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .done_i             (done),
        .order_i            (order),
        .window_data_i      (window_data),
        .reorder_vld_o      (reorder_vld_o),
        .reorder_ranks_o    (reorder_ranks_o)
    );

endmodule

// File: rtl/sorter_window.sv
`include "sorter_defs.svh"

module sorter_window (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  sorter_ctrl_pkg::ins_t                       ins_i,
    output sorter_data_pkg::data_t [`SORTER_WINDOW-1:0] window_data_o,
    output sorter_ctrl_pkg::slot_t                      oldest_slot_o,
    output sorter_ctrl_pkg::slot_rank_table_t           slot_ranks_o,
    output logic                                        update_o
);
    import sorter_ctrl_pkg::*;

    rank_t old_rank;

    // Rank currently held by the slot being replaced
    assign old_rank = slot_ranks_o[ins_i.slot];

    //////////////////////////////
    // Data memory
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            window_data_o <= '0;
        end else if (ins_i.valid) begin
            window_data_o[ins_i.slot] <= ins_i.data;
        end
    end

    //////////////////////////////
    // Slot ranks and pointer
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < `SORTER_WINDOW; k++) begin
                slot_ranks_o[k] <= rank_t'(k);
            end
            oldest_slot_o <= '0;
            update_o      <= 1'b0;
        end else begin
            update_o <= ins_i.valid;
            if (ins_i.valid) begin
                for (int k = 0; k < `SORTER_WINDOW; k++) begin
                    if (slot_t'(k) == ins_i.slot) begin
                        slot_ranks_o[k] <= ins_i.rank;
                    end else if (ins_i.rank <= old_rank) begin
                        // New value lands at or below the old one, shift up
                        if (slot_ranks_o[k] >= ins_i.rank && slot_ranks_o[k] < old_rank) begin
                            slot_ranks_o[k] <= slot_ranks_o[k] + 1'b1;
                        end
                    end else begin
                        // New value lands above, close the gap downwards
                        if (slot_ranks_o[k] > old_rank && slot_ranks_o[k] <= ins_i.rank) begin
                            slot_ranks_o[k] <= slot_ranks_o[k] - 1'b1;
                        end
                    end
                end
                if (oldest_slot_o == slot_t'(`SORTER_WINDOW - 1)) begin
                    oldest_slot_o <= '0;
                end else begin
                    oldest_slot_o <= oldest_slot_o + 1'b1;
                end
            end
        end
    end

endmodule

// File: sim.f
+incdir+common
+incdir+test
common/sorter_data_pkg.sv
common/sorter_ctrl_pkg.sv
rtl/sorter_compare.sv
rtl/sorter_rank_count.sv
rtl/sorter_window.sv
rtl/sorter_order_scan.sv
rtl/sorter_output.sv
rtl/sorter_top.sv
test/tb_sorter.sv

// File: test/tb_sorter_model.svh
`ifndef TB_SORTER_MODEL_SVH
`define TB_SORTER_MODEL_SVH

// Last 15 samples in arrival order, zero after reset
data_t  model_win [`SORTER_WINDOW];
int     model_head;

function automatic void model_clear();
    for (int k = 0; k < `SORTER_WINDOW; k++) begin
        model_win[k] = '0;
    end
    model_head = 0;
endfunction

// Newest sample overwrites the oldest one
function automatic void model_push(data_t sample);
    model_win[model_head] = sample;
    model_head = (model_head + 1) % `SORTER_WINDOW;
endfunction

// Eight smallest values, ascending
function automatic rank_vec_t model_ranks();
    data_t      s [`SORTER_WINDOW];
    data_t      t;
    rank_vec_t  res;
    s = model_win;
    for (int i = 0; i < `SORTER_WINDOW - 1; i++) begin
        for (int j = 0; j < `SORTER_WINDOW - 1 - i; j++) begin
            if (s[j] > s[j+1]) begin
                t      = s[j];
                s[j]   = s[j+1];
                s[j+1] = t;
            end
        end
    end
    for (int r = 0; r < `SORTER_OUT_RANKS; r++) begin
        res[r] = s[r];
    end
    return res;
endfunction

`endif

// File: test/tb_sorter.sv
`include "sorter_defs.svh"

module tb_sorter;
    import sorter_data_pkg::*;

    localparam int ROWS        = 21;
    localparam int RAND_COUNT  = 60;
    localparam int MIN_GAP     = 20;
    localparam int MAX_GAP     = 26;
    localparam int SEED        = 22759;
    localparam int LATENCY     = 19;
    localparam int TIMEOUT_CYC = 16 + (ROWS + RAND_COUNT) * MAX_GAP + 100;

    logic       clk_i = 1'b0;
    logic       rst_i;
    logic       src_vld_i;
    data_t      src_data_i;
    logic       reorder_vld_o;
    rank_vec_t  reorder_ranks_o;

    int         edge_cnt  = 0;
    int         pulse_cnt = 0;
    int         sent_cnt  = 0;
    int         row_cnt   = 0;
    integer     seed;

    // Stimulus table
    string      row_name [ROWS];
    data_t      row_data [ROWS];
    int         row_gap  [ROWS];
    rank_vec_t  row_exp  [ROWS];

    `include "tb_sorter_model.svh"

    sorter_top DUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .src_vld_i       (src_vld_i),
        .src_data_i      (src_data_i),
        .reorder_vld_o   (reorder_vld_o),
        .reorder_ranks_o (reorder_ranks_o)
    );

    always #2 clk_i = ~clk_i;

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_ranks(string name, rank_vec_t exp, rank_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s ranks expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_vld(string name, int exp, int act);
        if (act != exp) begin
            abort_run($sformatf("Mismatch %s pulses expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            abort_run($sformatf("Mismatch %s latency expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Edge counter and run limit
    always @(posedge clk_i) begin
        edge_cnt = edge_cnt + 1;
        if (edge_cnt > TIMEOUT_CYC) begin
            abort_run("Run timed out before all samples produced an output pulse");
        end
    end

    // Pulses counted mid-cycle where the output is stable
    always @(negedge clk_i) begin
        if (reorder_vld_o) begin
            pulse_cnt = pulse_cnt + 1;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic add_row(string name, data_t d, int gap, data_t r0, data_t r1, data_t r2,
                           data_t r3, data_t r4, data_t r5, data_t r6, data_t r7);
        row_name[row_cnt] = name;
        row_data[row_cnt] = d;
        row_gap[row_cnt]  = gap;
        row_exp[row_cnt]  = {r7, r6, r5, r4, r3, r2, r1, r0};
        row_cnt++;
    endtask

    task automatic build_table();
        // Ascending fill, ten or more zeros remain
        add_row("fill_10",          10, 20,  0,  0,  0,  0,  0,   0,   0,   0);
        add_row("fill_20",          20, 21,  0,  0,  0,  0,  0,   0,   0,   0);
        add_row("fill_30",          30, 20,  0,  0,  0,  0,  0,   0,   0,   0);
        add_row("fill_40",          40, 22,  0,  0,  0,  0,  0,   0,   0,   0);
        add_row("fill_50",          50, 20,  0,  0,  0,  0,  0,   0,   0,   0);
        // Large values out of order push the zeros out
        add_row("large_900",       900, 20,  0,  0,  0,  0,  0,   0,   0,   0);
        add_row("large_300",       300, 23,  0,  0,  0,  0,  0,   0,   0,   0);
        add_row("large_700",       700, 20,  0,  0,  0,  0,  0,   0,   0,  10);
        add_row("large_100",       100, 20,  0,  0,  0,  0,  0,   0,  10,  20);
        add_row("large_800",       800, 21,  0,  0,  0,  0,  0,  10,  20,  30);
        add_row("large_200",       200, 20,  0,  0,  0,  0, 10,  20,  30,  40);
        add_row("large_600",       600, 20,  0,  0,  0, 10, 20,  30,  40,  50);
        add_row("large_400",       400, 22,  0,  0, 10, 20, 30,  40,  50, 100);
        add_row("large_500",       500, 20,  0, 10, 20, 30, 40,  50, 100, 200);
        add_row("large_1000",     1000, 20, 10, 20, 30, 40, 50, 100, 200, 300);
        // Small, equal and out of order values, oldest entries drop out
        add_row("evict_10_by_5",     5, 20,  5, 20, 30, 40, 50, 100, 200, 300);
        add_row("dup_30",           30, 21,  5, 30, 30, 40, 50, 100, 200, 300);
        add_row("dup_5",             5, 20,  5,  5, 30, 40, 50, 100, 200, 300);
        add_row("out_of_order_45",  45, 20,  5,  5, 30, 45, 50, 100, 200, 300);
        add_row("max_value",     65535, 23,  5,  5, 30, 45, 100, 200, 300, 400);
        add_row("evict_900_by_1",    1, 20,  1,  5,  5, 30, 45, 100, 200, 300);
    endtask

    // Strobe one sample, wait for its pulse, then hold off until the gap ends
    task automatic apply_sample(string name, data_t sample, int gap, rank_vec_t exp_ranks);
        int strobe_edge;
        src_vld_i  = 1'b1;
        src_data_i = sample;
        @(posedge clk_i);
        #1;
        strobe_edge = edge_cnt;
        src_vld_i   = 1'b0;
        sent_cnt++;
        while (!reorder_vld_o) begin
            @(posedge clk_i);
            #1;
        end
        check_vld(name, sent_cnt - 1, pulse_cnt);
        check_latency(name, LATENCY, edge_cnt - strobe_edge);
        check_ranks(name, exp_ranks, reorder_ranks_o);
        while (edge_cnt < strobe_edge + gap - 1) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        data_t  sample;
        int     gap;
        rst_i      = 1'b1;
        src_vld_i  = 1'b0;
        src_data_i = '0;
        seed       = SEED;
        model_clear();
        build_table();

        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        check_vld("reset", 0, pulse_cnt);

        // Hand-written table
        for (int i = 0; i < ROWS; i++) begin
            model_push(row_data[i]);
            apply_sample(row_name[i], row_data[i], row_gap[i], row_exp[i]);
        end

        // Random stream against the window model
        for (int i = 0; i < RAND_COUNT; i++) begin
            sample = data_t'($random(seed));
            gap    = MIN_GAP + int'($unsigned($random(seed)) % (MAX_GAP - MIN_GAP + 1));
            model_push(sample);
            apply_sample($sformatf("random_%0d", i), sample, gap, model_ranks());
        end

        repeat (30) @(posedge clk_i);
        #1;
        check_vld("final", sent_cnt, pulse_cnt);
        $display("TEST PASSED");
        $finish;
    end

endmodule
